// File: hw/vmem_settings.svh
`ifndef VMEM_SETTINGS_SVH
`define VMEM_SETTINGS_SVH

// AXI byte address width
`define VMEM_ADDR_W 32

// AXI data bus and stream width
`define VMEM_DATA_W 32

// Width of the transfer byte count from the vector core
`define VMEM_XFER_W 32

// Longest burst issued on the AXI bus, in beats
`define VMEM_MAX_BURST 16

`endif

// File: hw/vmem_pkg.sv
`include "vmem_settings.svh"

package vmem_pkg;

   typedef logic [`VMEM_ADDR_W-1:0]   addr_t;
   typedef logic [`VMEM_DATA_W-1:0]   data_t;
   typedef logic [`VMEM_DATA_W/8-1:0] strb_t;
   typedef logic [`VMEM_XFER_W-1:0]   xfer_size_t;

   // AXI len field holds beats minus one
   typedef logic [7:0]                axi_len_t;

   // Burst splitter FSM
   typedef enum logic {IDLE, EMIT} split_state_e;

   // Write engine FSM, one burst at a time
   typedef enum logic [1:0] {ADDR, DATA, WAIT_B} wr_state_e;

endpackage

// File: hw/vmem_burst_if.sv
interface vmem_burst_if;

   logic                 valid;
   logic                 ready;
   vmem_pkg::addr_t      addr;
   vmem_pkg::axi_len_t   len;
   // Final burst of the whole transfer
   logic                 last;

   modport splitter (
      output valid, addr, len, last,
      input  ready
   );

   modport engine (
      input  valid, addr, len, last,
      output ready
   );

endinterface

// File: hw/vmem_burst_splitter.sv
`include "vmem_settings.svh"

module vmem_burst_splitter (
   input  logic                 clk,
   input  logic                 arst_n_i,
   input  logic                 start_i,
   input  vmem_pkg::addr_t      addr_i,
   input  vmem_pkg::xfer_size_t size_i,
   input  logic                 done_i,
   output logic                 busy_o,
   vmem_burst_if.splitter       burst_o
);

   vmem_pkg::split_state_e state_q;
   vmem_pkg::addr_t        cur_addr_q;
   vmem_pkg::xfer_size_t   rem_beats_q;
   vmem_pkg::xfer_size_t   page_beats;
   vmem_pkg::xfer_size_t   beats;
   logic                   accept;
   logic                   burst_hs;

   assign accept   = start_i && !busy_o;
   assign burst_hs = burst_o.valid && burst_o.ready;

   // Beats left before the next 4 KB page
   assign page_beats =
      vmem_pkg::xfer_size_t'((13'h1000 - {1'b0, cur_addr_q[11:0]}) >> 2);

   // Smallest of remaining, max burst and page limit
   always_comb begin
      beats = rem_beats_q;
      if (beats > vmem_pkg::xfer_size_t'(`VMEM_MAX_BURST)) begin
         beats = vmem_pkg::xfer_size_t'(`VMEM_MAX_BURST);
      end
      if (beats > page_beats) begin
         beats = page_beats;
      end
   end

   assign burst_o.valid = (state_q == vmem_pkg::EMIT);
   assign burst_o.addr  = cur_addr_q;
   assign burst_o.len   = vmem_pkg::axi_len_t'(beats - vmem_pkg::xfer_size_t'(1));
   assign burst_o.last  = (rem_beats_q == beats);

   always_ff @(posedge clk or negedge arst_n_i) begin
      if (!arst_n_i) begin
         state_q <= vmem_pkg::IDLE;
         busy_o  <= 1'b0;
      end else begin
         case (state_q)
            vmem_pkg::IDLE: begin
               if (accept) begin
                  state_q <= vmem_pkg::EMIT;
               end
            end
            vmem_pkg::EMIT: begin
               if (burst_hs && burst_o.last) begin
                  state_q <= vmem_pkg::IDLE;
               end
            end
            default: state_q <= vmem_pkg::IDLE;
         endcase
         // Busy holds until the engine reports the end
         if (accept) begin
            busy_o <= 1'b1;
         end else if (done_i) begin
            busy_o <= 1'b0;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (accept) begin
         cur_addr_q  <= addr_i;
         rem_beats_q <= size_i >> 2;
      end else if (burst_hs) begin
         cur_addr_q  <= cur_addr_q + (vmem_pkg::addr_t'(beats) << 2);
         rem_beats_q <= rem_beats_q - beats;
      end
   end

endmodule

// File: hw/vmem_rd_engine.sv
module vmem_rd_engine (
   input  logic               clk,
   input  logic               arst_n_i,
   vmem_burst_if.engine       burst_i,
   output logic               m_axi_arvalid_o,
   input  logic               m_axi_arready_i,
   output vmem_pkg::addr_t    m_axi_araddr_o,
   output vmem_pkg::axi_len_t m_axi_arlen_o,
   input  logic               m_axi_rvalid_i,
   output logic               m_axi_rready_o,
   input  vmem_pkg::data_t    m_axi_rdata_i,
   input  logic               m_axi_rlast_i,
   output logic               rd_tvalid_o,
   input  logic               rd_tready_i,
   output vmem_pkg::data_t    rd_tdata_o,
   output logic               rd_tlast_o,
   output logic               done_o
);

   vmem_pkg::xfer_size_t open_cnt_q;
   logic                 final_seen_q;
   logic                 burst_hs;
   logic                 rlast_hs;

   // One pending AR at a time
   assign burst_i.ready = !m_axi_arvalid_o;
   assign burst_hs      = burst_i.valid && burst_i.ready;
   assign rlast_hs      = m_axi_rvalid_i && rd_tready_i && m_axi_rlast_i;

   // R channel goes straight to the stream
   assign rd_tvalid_o    = m_axi_rvalid_i;
   assign rd_tdata_o     = m_axi_rdata_i;
   assign m_axi_rready_o = rd_tready_i;

   // Only the final burst left open, so this rlast ends the transfer
   assign rd_tlast_o = m_axi_rlast_i && final_seen_q
                       && (open_cnt_q == vmem_pkg::xfer_size_t'(1));

   always_ff @(posedge clk or negedge arst_n_i) begin
      if (!arst_n_i) begin
         m_axi_arvalid_o <= 1'b0;
         open_cnt_q      <= '0;
         final_seen_q    <= 1'b0;
         done_o          <= 1'b0;
      end else begin
         if (burst_hs) begin
            m_axi_arvalid_o <= 1'b1;
         end else if (m_axi_arready_i) begin
            m_axi_arvalid_o <= 1'b0;
         end
         if (burst_hs && !rlast_hs) begin
            open_cnt_q <= open_cnt_q + vmem_pkg::xfer_size_t'(1);
         end else if (rlast_hs && !burst_hs) begin
            open_cnt_q <= open_cnt_q - vmem_pkg::xfer_size_t'(1);
         end
         if (burst_hs && burst_i.last) begin
            final_seen_q <= 1'b1;
         end else if (rlast_hs && rd_tlast_o) begin
            final_seen_q <= 1'b0;
         end
         done_o <= rlast_hs && rd_tlast_o;
      end
   end

   always_ff @(posedge clk) begin
      if (burst_hs) begin
         m_axi_araddr_o <= burst_i.addr;
         m_axi_arlen_o  <= burst_i.len;
      end
   end

endmodule

// File: hw/vmem_wr_engine.sv
module vmem_wr_engine (
   input  logic               clk,
   input  logic               arst_n_i,
   vmem_burst_if.engine       burst_i,
   output logic               m_axi_awvalid_o,
   input  logic               m_axi_awready_i,
   output vmem_pkg::addr_t    m_axi_awaddr_o,
   output vmem_pkg::axi_len_t m_axi_awlen_o,
   output logic               m_axi_wvalid_o,
   input  logic               m_axi_wready_i,
   output vmem_pkg::data_t    m_axi_wdata_o,
   output vmem_pkg::strb_t    m_axi_wstrb_o,
   output logic               m_axi_wlast_o,
   input  logic               m_axi_bvalid_i,
   output logic               m_axi_bready_o,
   input  logic               wr_tvalid_i,
   output logic               wr_tready_o,
   input  vmem_pkg::data_t    wr_tdata_i,
   output logic               done_o
);

   vmem_pkg::wr_state_e state_q;
   vmem_pkg::axi_len_t  beat_cnt_q;
   logic                last_q;
   logic                burst_hs;
   logic                w_hs;
   logic                in_data;

   assign in_data  = (state_q == vmem_pkg::DATA);
   assign burst_hs = burst_i.valid && burst_i.ready;
   assign w_hs     = m_axi_wvalid_o && m_axi_wready_i;

   // New burst only while no address is pending
   assign burst_i.ready = (state_q == vmem_pkg::ADDR) && !m_axi_awvalid_o;

   // Stream feeds W directly during the data phase
   assign m_axi_wvalid_o = in_data && wr_tvalid_i;
   assign wr_tready_o    = in_data && m_axi_wready_i;
   assign m_axi_wdata_o  = wr_tdata_i;
   assign m_axi_wstrb_o  = '1;
   assign m_axi_wlast_o  = (beat_cnt_q == m_axi_awlen_o);
   assign m_axi_bready_o = (state_q == vmem_pkg::WAIT_B);

   always_ff @(posedge clk or negedge arst_n_i) begin
      if (!arst_n_i) begin
         state_q         <= vmem_pkg::ADDR;
         m_axi_awvalid_o <= 1'b0;
         beat_cnt_q      <= '0;
         done_o          <= 1'b0;
      end else begin
         done_o <= 1'b0;
         case (state_q)
            vmem_pkg::ADDR: begin
               if (burst_hs) begin
                  m_axi_awvalid_o <= 1'b1;
               end else if (m_axi_awvalid_o && m_axi_awready_i) begin
                  m_axi_awvalid_o <= 1'b0;
                  beat_cnt_q      <= '0;
                  state_q         <= vmem_pkg::DATA;
               end
            end
            vmem_pkg::DATA: begin
               if (w_hs) begin
                  beat_cnt_q <= beat_cnt_q + 8'd1;
                  if (m_axi_wlast_o) begin
                     state_q <= vmem_pkg::WAIT_B;
                  end
               end
            end
            vmem_pkg::WAIT_B: begin
               if (m_axi_bvalid_i) begin
                  // Response of the final burst closes the transfer
                  done_o  <= last_q;
                  state_q <= vmem_pkg::ADDR;
               end
            end
            default: state_q <= vmem_pkg::ADDR;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (burst_hs) begin
         m_axi_awaddr_o <= burst_i.addr;
         m_axi_awlen_o  <= burst_i.len;
         last_q         <= burst_i.last;
      end
   end

endmodule

// File: hw/vmem_axim_ctrl.sv
module vmem_axim_ctrl (
   input  logic                 clk,
   input  logic                 arst_n_i,
   // AXI4 master
   output logic                 m_axi_awvalid_o,
   input  logic                 m_axi_awready_i,
   output vmem_pkg::addr_t      m_axi_awaddr_o,
   output vmem_pkg::axi_len_t   m_axi_awlen_o,
   output logic                 m_axi_wvalid_o,
   input  logic                 m_axi_wready_i,
   output vmem_pkg::data_t      m_axi_wdata_o,
   output vmem_pkg::strb_t      m_axi_wstrb_o,
   output logic                 m_axi_wlast_o,
   input  logic                 m_axi_bvalid_i,
   output logic                 m_axi_bready_o,
   output logic                 m_axi_arvalid_o,
   input  logic                 m_axi_arready_i,
   output vmem_pkg::addr_t      m_axi_araddr_o,
   output vmem_pkg::axi_len_t   m_axi_arlen_o,
   input  logic                 m_axi_rvalid_i,
   output logic                 m_axi_rready_o,
   input  vmem_pkg::data_t      m_axi_rdata_i,
   input  logic                 m_axi_rlast_i,
   // Vector core read side
   input  logic                 ctrl_rstart_i,
   input  vmem_pkg::addr_t      ctrl_raddr_offset_i,
   input  vmem_pkg::xfer_size_t ctrl_rxfer_size_i,
   output logic                 ctrl_rbusy_o,
   output logic                 ctrl_rdone_o,
   output logic                 rd_tvalid_o,
   input  logic                 rd_tready_i,
   output vmem_pkg::data_t      rd_tdata_o,
   output logic                 rd_tlast_o,
   // Vector core write side
   input  logic                 ctrl_wstart_i,
   input  vmem_pkg::addr_t      ctrl_waddr_offset_i,
   input  vmem_pkg::xfer_size_t ctrl_wxfer_size_i,
   output logic                 ctrl_wbusy_o,
   output logic                 ctrl_wdone_o,
   input  logic                 wr_tvalid_i,
   output logic                 wr_tready_o,
   input  vmem_pkg::data_t      wr_tdata_i
);

   vmem_burst_if rd_burst ();
   vmem_burst_if wr_burst ();

   vmem_burst_splitter rd_split_i (
      .clk      (clk),
      .arst_n_i (arst_n_i),
      .start_i  (ctrl_rstart_i),
      .addr_i   (ctrl_raddr_offset_i),
      .size_i   (ctrl_rxfer_size_i),
      .done_i   (ctrl_rdone_o),
      .busy_o   (ctrl_rbusy_o),
      .burst_o  (rd_burst.splitter)
   );

   vmem_rd_engine rd_engine_i (
      .clk             (clk),
      .arst_n_i        (arst_n_i),
      .burst_i         (rd_burst.engine),
      .m_axi_arvalid_o (m_axi_arvalid_o),
      .m_axi_arready_i (m_axi_arready_i),
      .m_axi_araddr_o  (m_axi_araddr_o),
      .m_axi_arlen_o   (m_axi_arlen_o),
      .m_axi_rvalid_i  (m_axi_rvalid_i),
      .m_axi_rready_o  (m_axi_rready_o),
      .m_axi_rdata_i   (m_axi_rdata_i),
      .m_axi_rlast_i   (m_axi_rlast_i),
      .rd_tvalid_o     (rd_tvalid_o),
      .rd_tready_i     (rd_tready_i),
      .rd_tdata_o      (rd_tdata_o),
      .rd_tlast_o      (rd_tlast_o),
      .done_o          (ctrl_rdone_o)
   );

   vmem_burst_splitter wr_split_i (
      .clk      (clk),
      .arst_n_i (arst_n_i),
      .start_i  (ctrl_wstart_i),
      .addr_i   (ctrl_waddr_offset_i),
      .size_i   (ctrl_wxfer_size_i),
      .done_i   (ctrl_wdone_o),
      .busy_o   (ctrl_wbusy_o),
      .burst_o  (wr_burst.splitter)
   );

   vmem_wr_engine wr_engine_i (
      .clk             (clk),
      .arst_n_i        (arst_n_i),
      .burst_i         (wr_burst.engine),
      .m_axi_awvalid_o (m_axi_awvalid_o),
      .m_axi_awready_i (m_axi_awready_i),
      .m_axi_awaddr_o  (m_axi_awaddr_o),
      .m_axi_awlen_o   (m_axi_awlen_o),
      .m_axi_wvalid_o  (m_axi_wvalid_o),
      .m_axi_wready_i  (m_axi_wready_i),
      .m_axi_wdata_o   (m_axi_wdata_o),
      .m_axi_wstrb_o   (m_axi_wstrb_o),
      .m_axi_wlast_o   (m_axi_wlast_o),
      .m_axi_bvalid_i  (m_axi_bvalid_i),
      .m_axi_bready_o  (m_axi_bready_o),
      .wr_tvalid_i     (wr_tvalid_i),
      .wr_tready_o     (wr_tready_o),
      .wr_tdata_i      (wr_tdata_i),
      .done_o          (ctrl_wdone_o)
   );

endmodule

// File: dv/tb_clk_gen.sv
module tb_clk_gen (
   output logic clk_o,
   output logic arst_n_o
);

   timeunit 1ns;
   timeprecision 100ps;

   initial begin
      clk_o = 1'b0;
      forever #2 clk_o = ~clk_o;
   end

   // Reset held for 8 cycles, released off the edge
   initial begin
      arst_n_o = 1'b0;
      repeat (8) @(posedge clk_o);
      #1 arst_n_o = 1'b1;
   end

endmodule

// File: dv/tb_axi_mem.sv
`include "vmem_settings.svh"

module tb_axi_mem (
   input  logic               clk_i,
   input  logic               awvalid_i,
   output logic               awready_o,
   input  vmem_pkg::addr_t    awaddr_i,
   input  vmem_pkg::axi_len_t awlen_i,
   input  logic               wvalid_i,
   output logic               wready_o,
   input  vmem_pkg::data_t    wdata_i,
   input  vmem_pkg::strb_t    wstrb_i,
   input  logic               wlast_i,
   output logic               bvalid_o,
   input  logic               bready_i,
   input  logic               arvalid_i,
   output logic               arready_o,
   input  vmem_pkg::addr_t    araddr_i,
   input  vmem_pkg::axi_len_t arlen_i,
   output logic               rvalid_o,
   input  logic               rready_i,
   output vmem_pkg::data_t    rdata_o,
   output logic               rlast_o
);

   timeunit 1ns;
   timeprecision 100ps;

   localparam int BEAT_BYTES = `VMEM_DATA_W / 8;
   // Read data is the word address plus this offset
   localparam vmem_pkg::data_t RD_BASE = 32'h5a00_0000;

   // Bursts seen on AR and AW, in arrival order
   vmem_pkg::addr_t    ar_addr_q[$];
   vmem_pkg::axi_len_t ar_len_q[$];
   vmem_pkg::addr_t    aw_addr_q[$];
   vmem_pkg::axi_len_t aw_len_q[$];
   // Written words, indexed by word address
   vmem_pkg::data_t    words[vmem_pkg::addr_t];
   int                 wlast_err;
   int                 wstrb_err;
   // B responses taken by the master
   int                 b_cnt;

   // Read bursts still owed R beats
   vmem_pkg::addr_t    rd_addr_q[$];
   int                 rd_left_q[$];
   vmem_pkg::addr_t    wr_addr;
   int                 wr_left;
   logic               b_due;
   logic               r_fire;
   logic               b_fire;

   initial begin
      awready_o = 1'b0;
      wready_o  = 1'b0;
      bvalid_o  = 1'b0;
      arready_o = 1'b0;
      rvalid_o  = 1'b0;
      rdata_o   = '0;
      rlast_o   = 1'b0;
      wlast_err = 0;
      wstrb_err = 0;
      b_cnt     = 0;
      wr_addr   = '0;
      wr_left   = 0;
      b_due     = 1'b0;
   end

   always begin
      // Handshakes taken from settled values half a cycle before the edge
      @(negedge clk_i);
      r_fire = rvalid_o && rready_i;
      b_fire = bvalid_o && bready_i;
      if (b_fire) b_cnt++;
      if (arvalid_i && arready_o) begin
         ar_addr_q.push_back(araddr_i);
         ar_len_q.push_back(arlen_i);
         rd_addr_q.push_back(araddr_i);
         rd_left_q.push_back(int'(arlen_i) + 1);
      end
      if (r_fire) begin
         rd_addr_q[0] = rd_addr_q[0] + vmem_pkg::addr_t'(BEAT_BYTES);
         rd_left_q[0] = rd_left_q[0] - 1;
         if (rd_left_q[0] == 0) begin
            void'(rd_addr_q.pop_front());
            void'(rd_left_q.pop_front());
         end
      end
      if (awvalid_i && awready_o) begin
         aw_addr_q.push_back(awaddr_i);
         aw_len_q.push_back(awlen_i);
         wr_addr = awaddr_i;
         wr_left = int'(awlen_i) + 1;
      end
      if (wvalid_i && wready_o) begin
         words[wr_addr / BEAT_BYTES] = wdata_i;
         if (wstrb_i != '1) wstrb_err++;
         if (wlast_i != (wr_left == 1)) wlast_err++;
         wr_addr = wr_addr + vmem_pkg::addr_t'(BEAT_BYTES);
         wr_left = wr_left - 1;
         if (wr_left == 0) b_due = 1'b1;
      end

      @(posedge clk_i);
      #1;
      // Readies stall at random, valids hold until taken
      arready_o = ($urandom % 4) != 0;
      awready_o = ($urandom % 4) != 0;
      wready_o  = ($urandom % 4) != 0;
      if (!rvalid_o || r_fire) begin
         rvalid_o = 1'b0;
         if (rd_left_q.size() > 0 && ($urandom % 4) != 0) begin
            rvalid_o = 1'b1;
            rdata_o  = vmem_pkg::data_t'(rd_addr_q[0] / BEAT_BYTES) + RD_BASE;
            rlast_o  = rd_left_q[0] == 1;
         end
      end
      if (b_fire) bvalid_o = 1'b0;
      if (b_due && !bvalid_o) begin
         bvalid_o = 1'b1;
         b_due    = 1'b0;
      end
   end

endmodule

// File: dv/tb_vmem_axim_ctrl.sv
`include "vmem_settings.svh"

module tb_vmem_axim_ctrl;

   timeunit 1ns;
   timeprecision 100ps;

   localparam int              TIMEOUT    = 2000;
   localparam int              BEAT_BYTES = `VMEM_DATA_W / 8;
   localparam vmem_pkg::data_t RD_BASE    = 32'h5a00_0000;

   logic clk;
   logic arst_n_i;
   logic m_axi_awvalid_o, m_axi_awready_i, m_axi_wvalid_o, m_axi_wready_i;
   logic m_axi_wlast_o, m_axi_bvalid_i, m_axi_bready_o;
   logic m_axi_arvalid_o, m_axi_arready_i, m_axi_rvalid_i, m_axi_rready_o, m_axi_rlast_i;
   vmem_pkg::addr_t      m_axi_awaddr_o, m_axi_araddr_o;
   vmem_pkg::axi_len_t   m_axi_awlen_o, m_axi_arlen_o;
   vmem_pkg::data_t      m_axi_wdata_o, m_axi_rdata_i, rd_tdata_o, wr_tdata_i;
   vmem_pkg::strb_t      m_axi_wstrb_o;
   vmem_pkg::addr_t      ctrl_raddr_offset_i, ctrl_waddr_offset_i;
   vmem_pkg::xfer_size_t ctrl_rxfer_size_i, ctrl_wxfer_size_i;
   logic ctrl_rstart_i, ctrl_rbusy_o, ctrl_rdone_o, rd_tvalid_o, rd_tready_i, rd_tlast_o;
   logic ctrl_wstart_i, ctrl_wbusy_o, ctrl_wdone_o, wr_tvalid_i, wr_tready_o;

   int checks;
   int errors;

   tb_clk_gen clk_gen_i (
      .clk_o    (clk),
      .arst_n_o (arst_n_i)
   );

   vmem_axim_ctrl vmem_axim_ctrl_i (.*);

   tb_axi_mem mem_i (
      .clk_i     (clk),
      .awvalid_i (m_axi_awvalid_o),
      .awready_o (m_axi_awready_i),
      .awaddr_i  (m_axi_awaddr_o),
      .awlen_i   (m_axi_awlen_o),
      .wvalid_i  (m_axi_wvalid_o),
      .wready_o  (m_axi_wready_i),
      .wdata_i   (m_axi_wdata_o),
      .wstrb_i   (m_axi_wstrb_o),
      .wlast_i   (m_axi_wlast_o),
      .bvalid_o  (m_axi_bvalid_i),
      .bready_i  (m_axi_bready_o),
      .arvalid_i (m_axi_arvalid_o),
      .arready_o (m_axi_arready_i),
      .araddr_i  (m_axi_araddr_o),
      .arlen_i   (m_axi_arlen_o),
      .rvalid_o  (m_axi_rvalid_i),
      .rready_i  (m_axi_rready_o),
      .rdata_o   (m_axi_rdata_i),
      .rlast_o   (m_axi_rlast_i)
   );

   task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
      checks++;
      if (exp !== act) begin
         errors++;
         $display("FAIL %s: expected %h, got %h", name, exp, act);
      end
   endtask

   task automatic next_cycle();
      @(posedge clk);
      #1;
   endtask

   // Data the memory model returns for a byte address
   function automatic vmem_pkg::data_t model_word(input vmem_pkg::addr_t a);
      return vmem_pkg::data_t'(a / BEAT_BYTES) + RD_BASE;
   endfunction

   // Walks the 4 KB and max-length rule and compares with the logged bursts
   task automatic compare_bursts(input bit is_wr, input vmem_pkg::addr_t addr,
                                 input int bytes, input int first);
      int beats;
      int to_page;
      int idx;
      idx = first;
      while (bytes > 0) begin
         beats = bytes / BEAT_BYTES;
         if (beats > `VMEM_MAX_BURST) beats = `VMEM_MAX_BURST;
         to_page = (4096 - int'(addr[11:0])) / BEAT_BYTES;
         if (beats > to_page) beats = to_page;
         if (is_wr) begin
            check("m_axi_awaddr_o", addr, mem_i.aw_addr_q[idx]);
            check("m_axi_awlen_o", beats - 1, 32'(mem_i.aw_len_q[idx]));
         end else begin
            check("m_axi_araddr_o", addr, mem_i.ar_addr_q[idx]);
            check("m_axi_arlen_o", beats - 1, 32'(mem_i.ar_len_q[idx]));
         end
         addr  = addr + vmem_pkg::addr_t'(beats * BEAT_BYTES);
         bytes = bytes - beats * BEAT_BYTES;
         idx++;
      end
      if (is_wr) begin
         check("AW burst count", idx, mem_i.aw_addr_q.size());
      end else begin
         check("AR burst count", idx, mem_i.ar_addr_q.size());
      end
   endtask

   task automatic test_reset();
      int cyc;
      cyc = 0;
      while (!arst_n_i && cyc < 50) begin
         next_cycle();
         cyc++;
      end
      if (!arst_n_i) begin
         $display("ERROR: reset was never released");
         errors++;
      end
      check("m_axi_arvalid_o", 0, 32'(m_axi_arvalid_o));
      check("m_axi_awvalid_o", 0, 32'(m_axi_awvalid_o));
      check("m_axi_wvalid_o", 0, 32'(m_axi_wvalid_o));
      check("rd_tvalid_o", 0, 32'(rd_tvalid_o));
      check("wr_tready_o", 0, 32'(wr_tready_o));
      check("ctrl_rbusy_o", 0, 32'(ctrl_rbusy_o));
      check("ctrl_wbusy_o", 0, 32'(ctrl_wbusy_o));
      check("ctrl_rdone_o", 0, 32'(ctrl_rdone_o));
      check("ctrl_wdone_o", 0, 32'(ctrl_wdone_o));
   endtask

   // bp toggles rd_tready_i, restart pulses a second start while busy
   task automatic run_read(input vmem_pkg::addr_t addr, input int bytes,
                           input bit bp, input bit restart);
      int beats;
      int n;
      int dones;
      int settle;
      int cyc;
      int first;
      beats  = bytes / BEAT_BYTES;
      first  = mem_i.ar_addr_q.size();
      n      = 0;
      dones  = 0;
      settle = 0;
      cyc    = 0;
      ctrl_raddr_offset_i = addr;
      ctrl_rxfer_size_i   = bytes;
      ctrl_rstart_i       = 1'b1;
      next_cycle();
      ctrl_rstart_i = 1'b0;
      check("ctrl_rbusy_o", 1, 32'(ctrl_rbusy_o));
      // Runs a few cycles past done to catch stray pulses
      while (cyc < TIMEOUT && settle < 8) begin
         @(negedge clk);
         if (rd_tvalid_o && rd_tready_i) begin
            check("rd_tdata_o", model_word(addr + vmem_pkg::addr_t'(n * BEAT_BYTES)),
                  rd_tdata_o);
            check("rd_tlast_o", 32'(n == beats - 1), 32'(rd_tlast_o));
            n++;
         end
         if (ctrl_rdone_o) dones++;
         if (dones > 0) settle++;
         next_cycle();
         cyc++;
         ctrl_rstart_i = restart && (cyc == 3);
         if (ctrl_rstart_i) check("ctrl_rbusy_o", 1, 32'(ctrl_rbusy_o));
         if (bp) rd_tready_i = ($urandom % 2) == 0;
      end
      rd_tready_i = 1'b1;
      if (dones == 0) begin
         $display("ERROR: read at %h timed out waiting for ctrl_rdone_o", addr);
         errors++;
      end
      check("ctrl_rdone_o pulses", 1, dones);
      check("ctrl_rbusy_o", 0, 32'(ctrl_rbusy_o));
      check("rd_tvalid_o beats", beats, n);
      compare_bursts(1'b0, addr, bytes, first);
   endtask

   task automatic run_write(input vmem_pkg::addr_t addr, input int bytes);
      vmem_pkg::data_t data_q[$];
      int beats;
      int n;
      int i;
      int dones;
      int settle;
      int cyc;
      int first;
      int wlast0;
      int wstrb0;
      int b0;
      logic fire;
      beats  = bytes / BEAT_BYTES;
      first  = mem_i.aw_addr_q.size();
      wlast0 = mem_i.wlast_err;
      wstrb0 = mem_i.wstrb_err;
      b0     = mem_i.b_cnt;
      n      = 0;
      dones  = 0;
      settle = 0;
      cyc    = 0;
      for (i = 0; i < beats; i++) data_q.push_back($urandom);
      ctrl_waddr_offset_i = addr;
      ctrl_wxfer_size_i   = bytes;
      ctrl_wstart_i       = 1'b1;
      next_cycle();
      ctrl_wstart_i = 1'b0;
      check("ctrl_wbusy_o", 1, 32'(ctrl_wbusy_o));
      while (cyc < TIMEOUT && settle < 8) begin
         @(negedge clk);
         fire = wr_tvalid_i && wr_tready_o;
         if (fire) n++;
         if (ctrl_wdone_o) dones++;
         if (dones > 0) settle++;
         next_cycle();
         cyc++;
         // Source stalls at random but holds a word until it is taken
         if (!wr_tvalid_i || fire) begin
            wr_tvalid_i = (n < beats) && (($urandom % 3) != 0);
            if (n < beats) wr_tdata_i = data_q[n];
         end
      end
      wr_tvalid_i = 1'b0;
      if (dones == 0) begin
         $display("ERROR: write at %h timed out waiting for ctrl_wdone_o", addr);
         errors++;
      end
      check("ctrl_wdone_o pulses", 1, dones);
      check("ctrl_wbusy_o", 0, 32'(ctrl_wbusy_o));
      check("wr_tvalid_i beats", beats, n);
      for (i = 0; i < beats; i++) begin
         check("m_axi_wdata_o", data_q[i],
               mem_i.words[vmem_pkg::addr_t'(addr / BEAT_BYTES + i)]);
      end
      check("m_axi_wlast_o misplaced", wlast0, mem_i.wlast_err);
      check("m_axi_wstrb_o not all set", wstrb0, mem_i.wstrb_err);
      // One B handshake per AW burst
      check("m_axi_bready_o handshakes", mem_i.aw_addr_q.size() - first,
            mem_i.b_cnt - b0);
      compare_bursts(1'b1, addr, bytes, first);
   endtask

   initial begin
      void'($urandom(32'h10d6_7e0a));
      checks              = 0;
      errors              = 0;
      ctrl_rstart_i       = 1'b0;
      ctrl_raddr_offset_i = '0;
      ctrl_rxfer_size_i   = '0;
      ctrl_wstart_i       = 1'b0;
      ctrl_waddr_offset_i = '0;
      ctrl_wxfer_size_i   = '0;
      rd_tready_i         = 1'b1;
      wr_tvalid_i         = 1'b0;
      wr_tdata_i          = '0;

      test_reset();
      // One aligned burst of 16 beats
      run_read(32'h0000_1000, 64, 1'b0, 1'b0);
      // Starts 32 bytes below a page end
      run_read(32'h0000_2fe0, 96, 1'b0, 1'b0);
      // Page split plus max-length bursts under stalls
      run_write(32'h0000_3fe8, 160);
      run_read(32'h0000_5ff0, 128, 1'b1, 1'b0);
      // Ignored restart, with a write running alongside
      fork
         run_read(32'h0000_6000, 64, 1'b0, 1'b1);
         run_write(32'h0000_7ff0, 48);
      join

      $display("checks: %0d, errors: %0d", checks, errors);
      if (errors == 0) begin
         $display("sim passed");
      end else begin
         $display("sim failed");
      end
      $finish;
   end

endmodule

// File: list.f
+incdir+hw
hw/vmem_pkg.sv
hw/vmem_burst_if.sv
hw/vmem_burst_splitter.sv
hw/vmem_rd_engine.sv
hw/vmem_wr_engine.sv
hw/vmem_axim_ctrl.sv
dv/tb_clk_gen.sv
dv/tb_axi_mem.sv
dv/tb_vmem_axim_ctrl.sv

// File: run_sim.sh
#!/bin/sh
# Build the testbench with Verilator, run it, and look for the pass line in the log
set -e
cd "$(dirname "$0")"
rm -rf obj_dir
verilator --binary --timing --timescale 1ns/100ps \
   --top-module tb_vmem_axim_ctrl -f list.f -o tb_sim
./obj_dir/tb_sim | tee sim.log
grep -q "^sim passed$" sim.log
